// ==== ckpt_top.f ====
+incdir+rtl
rtl/ckpt_pkg.sv
rtl/ckpt_buffer.sv
rtl/ckpt_dma.sv
rtl/scan_target.sv
rtl/scan_chain_ctrl.sv
rtl/ckpt_top.sv
test/ckpt_top_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing
TOP       := ckpt_top_tb
FILELIST  := ckpt_top.f
OBJ_DIR   := obj_dir
PASS_MSG  := all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== test/ckpt_top_tb.sv ====
`timescale 1ns/1ps
`include "ckpt_settings.svh"

module ckpt_top_tb;

    localparam int WORDS          = `CKPT_FF_COUNT + `CKPT_MEM_COUNT;
    localparam int N_TESTS        = 7;
    localparam int TIMEOUT_CYCLES = N_TESTS * 200;

    // Fill bit 0 loads the buffer before the first operation, bit 1 after it
    localparam logic [1:0] FILL_NONE   = 2'd0;
    localparam logic [1:0] FILL_BEFORE = 2'd1;
    localparam logic [1:0] FILL_AFTER  = 2'd2;
    localparam logic [1:0] FILL_BOTH   = 2'd3;
    localparam logic [1:0] OP_NONE     = 2'd0;
    localparam logic [1:0] OP_SCAN_IN  = 2'd1;
    localparam logic [1:0] OP_SCAN_OUT = 2'd2;
    localparam logic [1:0] RULE_WINDOW = 2'd0;
    localparam logic [1:0] RULE_ZERO   = 2'd1;
    localparam logic [1:0] RULE_MODEL  = 2'd2;

    // Steps are applied between the first and the second checkpoint operation
    typedef struct packed {
        logic [1:0] fill;
        logic [1:0] first_op;
        logic [7:0] steps;
        logic [1:0] second_op;
        logic       poke;
        logic [1:0] rule;
    } test_entry_t;

    logic                     host_clk = 1'b0;
    logic                     host_rst;
    ckpt_pkg::ctrl_wr_t       ctrl_wr;
    logic                     ctrl_ren;
    logic [`CKPT_CTRL_AW-1:0] ctrl_raddr;
    logic [31:0]              ctrl_rdata;
    logic                     step;

    string                test_names  [N_TESTS];
    test_entry_t          tests       [N_TESTS];
    ckpt_pkg::scan_word_t load_words  [WORDS];
    ckpt_pkg::scan_word_t model_words [WORDS];
    ckpt_pkg::scan_word_t dump_words  [WORDS];
    int                   cycle_count = 0;
    int                   err_count   = 0;
    int                   pass_count  = 0;
    int                   fail_count  = 0;

    ckpt_top DUT (
        .host_clk  (host_clk),
        .host_rst  (host_rst),
        .ctrl_wr   (ctrl_wr),
        .ctrl_ren  (ctrl_ren),
        .ctrl_raddr(ctrl_raddr),
        .ctrl_rdata(ctrl_rdata),
        .step      (step)
    );

    always #2 host_clk = ~host_clk;

    always @(posedge host_clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run timed out after %0d cycles", cycle_count);
            $display("tests failed");
            $finish;
        end
    end

    task automatic check_word(input string name, input int idx,
                              input ckpt_pkg::scan_word_t expected,
                              input ckpt_pkg::scan_word_t actual);
        if (actual !== expected) begin
            $display("Mismatch %s word %0d: expected %h, actual %h",
                     name, idx, expected, actual);
            err_count++;
        end
    endtask

    task automatic check_reg(input string name, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Mismatch %s %s: expected %h, actual %h", name, what, expected, actual);
            err_count++;
        end
    endtask

    // Every bus task starts and ends 1 ns after a rising edge
    task automatic host_write(input logic [`CKPT_CTRL_AW-1:0] addr, input logic [31:0] data);
        ctrl_wr.en   = 1'b1;
        ctrl_wr.addr = addr;
        ctrl_wr.data = data;
        @(posedge host_clk);
        #1;
        ctrl_wr.en = 1'b0;
    endtask

    task automatic host_read(input logic [`CKPT_CTRL_AW-1:0] addr, output logic [31:0] data);
        ctrl_ren   = 1'b1;
        ctrl_raddr = addr;
        #1;
        data = ctrl_rdata;
        @(posedge host_clk);
        #1;
        ctrl_ren = 1'b0;
    endtask

    task automatic draw_random_words();
        for (int i = 0; i < WORDS; i++) begin
            load_words[i] = {$urandom, $urandom};
        end
    endtask

    // The window address advances by itself after each high half
    task automatic buffer_load();
        host_write(`CKPT_REG_BUF_ADDR, 32'd0);
        for (int i = 0; i < WORDS; i++) begin
            host_write(`CKPT_REG_BUF_LO, load_words[i][31:0]);
            host_write(`CKPT_REG_BUF_HI, load_words[i][63:32]);
        end
    endtask

    task automatic buffer_dump();
        logic [31:0] lo;
        logic [31:0] hi;
        for (int i = 0; i < WORDS; i++) begin
            host_write(`CKPT_REG_BUF_ADDR, 32'(i));
            host_read(`CKPT_REG_BUF_LO, lo);
            host_read(`CKPT_REG_BUF_HI, hi);
            dump_words[i] = {hi, lo};
        end
    endtask

    task automatic hold_step(input int cycles);
        step = 1'b1;
        repeat (cycles) @(posedge host_clk);
        #1;
        step = 1'b0;
    endtask

    task automatic run_ckpt(input string name, input logic dir, input logic poke);
        logic [31:0] v;
        host_write(`CKPT_REG_DMA_CTRL, {30'd0, dir, 1'b1});
        if (poke) begin
            // A second start with the other direction lands while the sequence runs
            host_write(`CKPT_REG_DMA_CTRL, {30'd0, ~dir, 1'b1});
            host_read(`CKPT_REG_DMA_CTRL, v);
            check_reg(name, "DMA_CTRL while running", {30'd0, dir, 1'b1}, v);
        end
        v = 32'd1;
        while (v[0]) begin
            host_read(`CKPT_REG_DMA_CTRL, v);
        end
        check_reg(name, "DMA_CTRL at end", {30'd0, dir, 1'b0}, v);
    endtask

    task automatic fill_test_table();
        test_names[0] = "window_readback";
        tests[0]      = '{FILL_BEFORE, OP_NONE, 8'd0, OP_NONE, 1'b0, RULE_WINDOW};
        test_names[1] = "reset_scan_out";
        tests[1]      = '{FILL_NONE, OP_NONE, 8'd0, OP_SCAN_OUT, 1'b0, RULE_ZERO};
        test_names[2] = "round_trip";
        tests[2]      = '{FILL_BOTH, OP_SCAN_IN, 8'd0, OP_SCAN_OUT, 1'b0, RULE_MODEL};
        test_names[3] = "step_5";
        tests[3]      = '{FILL_BOTH, OP_SCAN_IN, 8'd5, OP_SCAN_OUT, 1'b0, RULE_MODEL};
        test_names[4] = "step_17";
        tests[4]      = '{FILL_BOTH, OP_SCAN_IN, 8'd17, OP_SCAN_OUT, 1'b0, RULE_MODEL};
        test_names[5] = "scan_out_twice";
        tests[5]      = '{FILL_AFTER, OP_SCAN_OUT, 8'd0, OP_SCAN_OUT, 1'b0, RULE_MODEL};
        test_names[6] = "busy_ctrl_write";
        tests[6]      = '{FILL_BOTH, OP_SCAN_IN, 8'd0, OP_SCAN_OUT, 1'b1, RULE_MODEL};
    endtask

    task automatic run_test(input int t);
        test_entry_t          e;
        string                name;
        int                   errs_before;
        logic [31:0]          v;
        e           = tests[t];
        name        = test_names[t];
        errs_before = err_count;
        if (e.rule == RULE_WINDOW) begin
            host_read(`CKPT_REG_DMA_CTRL, v);
            check_reg(name, "DMA_CTRL after reset", 32'd0, v);
        end
        if (e.fill[0]) begin
            draw_random_words();
            buffer_load();
        end
        if (e.rule == RULE_WINDOW) begin
            host_read(`CKPT_REG_BUF_ADDR, v);
            check_reg(name, "BUF_ADDR after load", 32'(WORDS), v);
        end
        if (e.first_op != OP_NONE) begin
            run_ckpt(name, e.first_op == OP_SCAN_IN, e.poke);
        end
        // After a scan-in the target holds the words that were in the buffer
        if (e.first_op == OP_SCAN_IN) begin
            model_words = load_words;
        end
        // A first scan-out must already show the modelled target state
        if (e.first_op == OP_SCAN_OUT) begin
            buffer_dump();
            for (int i = 0; i < WORDS; i++) begin
                check_word(name, i, model_words[i], dump_words[i]);
            end
        end
        // New buffer contents make sure the next scan-out really writes every word
        if (e.fill[1]) begin
            draw_random_words();
            buffer_load();
        end
        if (e.steps != 8'd0) begin
            hold_step(int'(e.steps));
            // Every flip-flop word gains one per stepped cycle
            for (int i = 0; i < `CKPT_FF_COUNT; i++) begin
                model_words[i] = model_words[i] + {56'd0, e.steps};
            end
        end
        if (e.second_op != OP_NONE) begin
            run_ckpt(name, e.second_op == OP_SCAN_IN, e.poke);
        end
        buffer_dump();
        for (int i = 0; i < WORDS; i++) begin
            if (e.rule == RULE_MODEL) begin
                check_word(name, i, model_words[i], dump_words[i]);
            end else if (e.rule == RULE_WINDOW) begin
                check_word(name, i, load_words[i], dump_words[i]);
            end else if (i < `CKPT_FF_COUNT) begin
                check_word(name, i, '0, dump_words[i]);
            end
        end
        if (err_count == errs_before) begin
            $display("PASS %s", name);
            pass_count++;
        end else begin
            $display("FAIL %s with %0d errors", name, err_count - errs_before);
            fail_count++;
        end
    endtask

    initial begin
        host_rst   = 1'b1;
        ctrl_wr    = '0;
        ctrl_ren   = 1'b0;
        ctrl_raddr = '0;
        step       = 1'b0;
        void'($urandom(6));
        fill_test_table();
        repeat (10) @(posedge host_clk);
        #1;
        host_rst = 1'b0;
        for (int t = 0; t < N_TESTS; t++) begin
            run_test(t);
        end
        $display("Tests run: %0d, passed: %0d, failed: %0d", N_TESTS, pass_count, fail_count);
        if (fail_count == 0 && err_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== rtl/ckpt_top.sv ====
`timescale 1ns/1ps
`include "ckpt_settings.svh"

module ckpt_top (
    input  logic                     host_clk,
    input  logic                     host_rst,
    input  ckpt_pkg::ctrl_wr_t       ctrl_wr,
    input  logic                     ctrl_ren,
    input  logic [`CKPT_CTRL_AW-1:0] ctrl_raddr,
    output logic [31:0]              ctrl_rdata,
    input  logic                     step
);

    logic                    running;
    ckpt_pkg::buf_host_t     buf_host;
    ckpt_pkg::scan_word_t    host_rdata;
    logic                    dma_start;
    logic                    dma_dir;
    logic                    dma_idle;
    ckpt_pkg::scan_beat_t    rd_beat;
    logic                    rd_ready;
    ckpt_pkg::scan_beat_t    wr_beat;
    logic                    wr_ready;
    logic                    buf_we;
    logic [`CKPT_BUF_AW-1:0] buf_addr;
    ckpt_pkg::scan_word_t    buf_wdata;
    ckpt_pkg::scan_word_t    buf_rdata;
    logic                    ff_se;
    ckpt_pkg::scan_word_t    ff_di;
    ckpt_pkg::scan_word_t    ff_do;
    logic                    ram_sr;
    logic                    ram_se;
    logic                    ram_sd;
    ckpt_pkg::scan_word_t    ram_di;
    ckpt_pkg::scan_word_t    ram_do;
    logic                    target_step;

    // The design must not advance while its state is being captured or restored
    assign target_step = step && !running;

    scan_chain_ctrl u_ctrl (
        .host_clk  (host_clk),   .host_rst  (host_rst),
        .ctrl_wr   (ctrl_wr),    .ctrl_ren  (ctrl_ren),
        .ctrl_raddr(ctrl_raddr), .ctrl_rdata(ctrl_rdata),
        .running   (running),    .buf_host  (buf_host),
        .host_rdata(host_rdata), .dma_start (dma_start),
        .dma_dir   (dma_dir),    .dma_idle  (dma_idle),
        .rd_beat   (rd_beat),    .rd_ready  (rd_ready),
        .wr_beat   (wr_beat),    .wr_ready  (wr_ready),
        .ff_se     (ff_se),      .ff_di     (ff_di),
        .ff_do     (ff_do),      .ram_sr    (ram_sr),
        .ram_se    (ram_se),     .ram_sd    (ram_sd),
        .ram_di    (ram_di),     .ram_do    (ram_do)
    );

    ckpt_dma u_dma (
        .host_clk (host_clk), .host_rst (host_rst),
        .start    (dma_start), .dir     (dma_dir),
        .idle     (dma_idle), .rd_beat  (rd_beat),
        .rd_ready (rd_ready), .wr_beat  (wr_beat),
        .wr_ready (wr_ready), .buf_we   (buf_we),
        .buf_addr (buf_addr), .buf_wdata(buf_wdata),
        .buf_rdata(buf_rdata)
    );

    ckpt_buffer u_buffer (
        .host_clk (host_clk),  .dma_we    (buf_we),
        .dma_addr (buf_addr),  .dma_wdata (buf_wdata),
        .dma_rdata(buf_rdata), .host      (buf_host),
        .host_rdata(host_rdata)
    );

    scan_target u_target (
        .host_clk(host_clk), .host_rst(host_rst), .step(target_step),
        .ff_se   (ff_se),    .ff_di   (ff_di),    .ff_do(ff_do),
        .ram_sr  (ram_sr),   .ram_se  (ram_se),   .ram_sd(ram_sd),
        .ram_di  (ram_di),   .ram_do  (ram_do)
    );

endmodule

// ==== rtl/scan_chain_ctrl.sv ====
`timescale 1ns/1ps
`include "ckpt_settings.svh"

module scan_chain_ctrl (
    input  logic                     host_clk,
    input  logic                     host_rst,
    input  ckpt_pkg::ctrl_wr_t       ctrl_wr,
    input  logic                     ctrl_ren,
    input  logic [`CKPT_CTRL_AW-1:0] ctrl_raddr,
    output logic [31:0]              ctrl_rdata,
    output logic                     running,
    output ckpt_pkg::buf_host_t      buf_host,
    input  ckpt_pkg::scan_word_t     host_rdata,
    output logic                     dma_start,
    output logic                     dma_dir,
    input  logic                     dma_idle,
    input  ckpt_pkg::scan_beat_t     rd_beat,
    output logic                     rd_ready,
    output ckpt_pkg::scan_beat_t     wr_beat,
    input  logic                     wr_ready,
    output logic                     ff_se,
    output ckpt_pkg::scan_word_t     ff_di,
    input  ckpt_pkg::scan_word_t     ff_do,
    output logic                     ram_sr,
    output logic                     ram_se,
    output logic                     ram_sd,
    output ckpt_pkg::scan_word_t     ram_di,
    input  ckpt_pkg::scan_word_t     ram_do
);

    localparam int FF_CW  = $clog2(`CKPT_FF_COUNT + 1);
    localparam int RAM_CW = $clog2(`CKPT_MEM_COUNT + 1);

    ckpt_pkg::scan_state_e   state;
    ckpt_pkg::scan_state_e   state_next;
    logic                    direction;
    logic [`CKPT_BUF_AW-1:0] buf_addr_q;
    logic [31:0]             lo_stage;
    logic [FF_CW-1:0]        ff_cnt;
    logic [RAM_CW-1:0]       ram_cnt;
    logic                    scan_ok;
    logic                    ff_last;
    logic                    ram_last;
    logic                    seq_done;
    logic                    host_hi_wr;

    // The stream side that can stall the scan depends on the direction
    assign scan_ok  = direction ? rd_beat.valid : wr_ready;
    assign ff_last  = (state == ckpt_pkg::ST_FF_SCAN) && (ff_cnt == FF_CW'(`CKPT_FF_COUNT - 1));
    assign ram_last = (state == ckpt_pkg::ST_RAM_SCAN) && (ram_cnt == RAM_CW'(`CKPT_MEM_COUNT - 1));
    assign seq_done = ram_last && scan_ok;

    // Buffer writes from the host are only allowed while the sequencer is idle
    assign host_hi_wr = ctrl_wr.en && (ctrl_wr.addr == `CKPT_REG_BUF_HI) && !running;

    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            running    <= 1'b0;
            direction  <= 1'b0;
            buf_addr_q <= '0;
            lo_stage   <= '0;
        end else begin
            if (seq_done) begin
                running <= 1'b0;
            end
            if (ctrl_wr.en && ctrl_wr.addr == `CKPT_REG_DMA_CTRL && !running) begin
                running   <= ctrl_wr.data[0];
                direction <= ctrl_wr.data[1];
            end
            if (ctrl_wr.en && ctrl_wr.addr == `CKPT_REG_BUF_ADDR) begin
                buf_addr_q <= ctrl_wr.data[`CKPT_BUF_AW-1:0];
            end
            if (ctrl_wr.en && ctrl_wr.addr == `CKPT_REG_BUF_LO) begin
                lo_stage <= ctrl_wr.data;
            end
            if (host_hi_wr) begin
                buf_addr_q <= buf_addr_q + 1'b1;
            end
        end
    end

    always_comb begin
        buf_host.we    = host_hi_wr;
        buf_host.addr  = buf_addr_q;
        buf_host.wdata = {ctrl_wr.data, lo_stage};
    end

    always_comb begin
        ctrl_rdata = '0;
        if (ctrl_ren) begin
            case (ctrl_raddr)
                `CKPT_REG_DMA_CTRL: ctrl_rdata = {30'd0, direction, running};
                `CKPT_REG_BUF_ADDR: ctrl_rdata = 32'(buf_addr_q);
                `CKPT_REG_BUF_LO:   ctrl_rdata = host_rdata[31:0];
                `CKPT_REG_BUF_HI:   ctrl_rdata = host_rdata[63:32];
                default:            ctrl_rdata = '0;
            endcase
        end
    end

    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            state <= ckpt_pkg::ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ckpt_pkg::ST_IDLE:      if (running) state_next = ckpt_pkg::ST_ADDR;
            ckpt_pkg::ST_ADDR:      state_next = ckpt_pkg::ST_COUNT;
            // The DMA leaves idle once it has taken the start and word count
            ckpt_pkg::ST_COUNT:     if (!dma_idle) state_next = ckpt_pkg::ST_FF_RESET;
            ckpt_pkg::ST_FF_RESET:  state_next = ckpt_pkg::ST_FF_SCAN;
            ckpt_pkg::ST_FF_SCAN:   if (ff_last && scan_ok) state_next = ckpt_pkg::ST_RAM_RESET;
            ckpt_pkg::ST_RAM_RESET: state_next = direction ? ckpt_pkg::ST_RAM_SCAN
                                                           : ckpt_pkg::ST_RAM_PREP1;
            ckpt_pkg::ST_RAM_PREP1: if (scan_ok) state_next = ckpt_pkg::ST_RAM_PREP2;
            ckpt_pkg::ST_RAM_PREP2: if (scan_ok) state_next = ckpt_pkg::ST_RAM_SCAN;
            ckpt_pkg::ST_RAM_SCAN:  if (seq_done) state_next = ckpt_pkg::ST_IDLE;
            default:                state_next = ckpt_pkg::ST_IDLE;
        endcase
    end

    // Word counters advance only on cycles where a word actually moves
    always_ff @(posedge host_clk) begin
        if (host_rst || state == ckpt_pkg::ST_FF_RESET) begin
            ff_cnt <= '0;
        end else if (ff_se) begin
            ff_cnt <= ff_cnt + 1'b1;
        end
    end

    always_ff @(posedge host_clk) begin
        if (host_rst || state == ckpt_pkg::ST_RAM_RESET) begin
            ram_cnt <= '0;
        end else if (state == ckpt_pkg::ST_RAM_SCAN && scan_ok) begin
            ram_cnt <= ram_cnt + 1'b1;
        end
    end

    assign dma_start = (state == ckpt_pkg::ST_ADDR);
    assign dma_dir   = direction;

    assign ff_se  = scan_ok && (state == ckpt_pkg::ST_FF_SCAN);
    // On scan-out the chain output is fed back so the design state survives
    assign ff_di  = direction ? rd_beat.data : ff_do;

    assign ram_sr = (state == ckpt_pkg::ST_RAM_RESET);
    assign ram_se = scan_ok && (state == ckpt_pkg::ST_RAM_PREP1 ||
                                state == ckpt_pkg::ST_RAM_PREP2 ||
                                state == ckpt_pkg::ST_RAM_SCAN);
    assign ram_sd = direction;
    assign ram_di = rd_beat.data;

    assign rd_ready = direction && (state == ckpt_pkg::ST_FF_SCAN ||
                                    state == ckpt_pkg::ST_RAM_SCAN);

    always_comb begin
        wr_beat.valid = !direction && (state == ckpt_pkg::ST_FF_SCAN ||
                                       state == ckpt_pkg::ST_RAM_SCAN);
        wr_beat.data  = (state == ckpt_pkg::ST_RAM_SCAN) ? ram_do : ff_do;
    end

endmodule

// ==== rtl/scan_target.sv ====
`timescale 1ns/1ps
`include "ckpt_settings.svh"

module scan_target (
    input  logic                 host_clk,
    input  logic                 host_rst,
    input  logic                 step,
    input  logic                 ff_se,
    input  ckpt_pkg::scan_word_t ff_di,
    output ckpt_pkg::scan_word_t ff_do,
    input  logic                 ram_sr,
    input  logic                 ram_se,
    input  logic                 ram_sd,
    input  ckpt_pkg::scan_word_t ram_di,
    output ckpt_pkg::scan_word_t ram_do
);

    localparam int FF_N  = `CKPT_FF_COUNT;
    localparam int MEM_N = `CKPT_MEM_COUNT;
    localparam int MEM_AW = $clog2(MEM_N);

    ckpt_pkg::scan_word_t ff_q [FF_N];
    ckpt_pkg::scan_word_t mem  [MEM_N];
    ckpt_pkg::scan_word_t rd_stage1;
    ckpt_pkg::scan_word_t rd_stage2;
    logic [MEM_AW:0]      ptr;

    // Word 0 takes the scan input and the last word drives the scan output
    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            for (int i = 0; i < FF_N; i++) begin
                ff_q[i] <= '0;
            end
        end else if (ff_se) begin
            ff_q[0] <= ff_di;
            for (int i = 1; i < FF_N; i++) begin
                ff_q[i] <= ff_q[i-1];
            end
        end else if (step) begin
            for (int i = 0; i < FF_N; i++) begin
                ff_q[i] <= ff_q[i] + 1'b1;
            end
        end
    end

    assign ff_do = ff_q[FF_N-1];

    // The pointer runs two words past the end on scan-out while the pipeline drains
    always_ff @(posedge host_clk) begin
        if (host_rst || ram_sr) begin
            ptr <= '0;
        end else if (ram_se) begin
            ptr <= ptr + 1'b1;
        end
    end

    always_ff @(posedge host_clk) begin
        if (ram_se && ram_sd) begin
            mem[ptr[MEM_AW-1:0]] <= ram_di;
        end
    end

    // Read path of the RAM model has two register stages
    always_ff @(posedge host_clk) begin
        if (ram_se && !ram_sd) begin
            rd_stage1 <= mem[ptr[MEM_AW-1:0]];
            rd_stage2 <= rd_stage1;
        end
    end

    assign ram_do = rd_stage2;

endmodule

// ==== rtl/ckpt_dma.sv ====
`timescale 1ns/1ps
`include "ckpt_settings.svh"

module ckpt_dma (
    input  logic                     host_clk,
    input  logic                     host_rst,
    input  logic                     start,
    input  logic                     dir,
    output logic                     idle,
    output ckpt_pkg::scan_beat_t     rd_beat,
    input  logic                     rd_ready,
    input  ckpt_pkg::scan_beat_t     wr_beat,
    output logic                     wr_ready,
    output logic                     buf_we,
    output logic [`CKPT_BUF_AW-1:0]  buf_addr,
    output ckpt_pkg::scan_word_t     buf_wdata,
    input  ckpt_pkg::scan_word_t     buf_rdata
);

    localparam int WORDS = `CKPT_FF_COUNT + `CKPT_MEM_COUNT;
    localparam int CNT_W = $clog2(WORDS + 1);

    logic                    busy;
    logic                    rd_valid;
    logic [`CKPT_BUF_AW-1:0] addr;
    logic [CNT_W-1:0]        remain;
    logic                    rd_fire;
    logic                    wr_fire;
    logic                    beat;
    logic                    last;

    assign rd_fire = rd_valid && rd_ready;
    assign wr_fire = wr_beat.valid && wr_ready;
    assign beat    = rd_fire || wr_fire;
    assign last    = (remain == CNT_W'(1));

    always_ff @(posedge host_clk) begin
        if (host_rst) begin
            busy     <= 1'b0;
            rd_valid <= 1'b0;
            addr     <= '0;
            remain   <= '0;
        end else if (start) begin
            busy     <= 1'b1;
            rd_valid <= 1'b0;
            addr     <= '0;
            remain   <= CNT_W'(WORDS);
        end else if (busy) begin
            if (beat) begin
                addr   <= addr + 1'b1;
                remain <= remain - 1'b1;
            end
            if (beat && last) begin
                busy     <= 1'b0;
                rd_valid <= 1'b0;
            end else if (dir) begin
                rd_valid <= 1'b1;
            end
        end
    end

    // Reading one word ahead keeps the next beat ready as soon as one is taken
    assign buf_addr  = rd_fire ? addr + 1'b1 : addr;
    assign buf_we    = wr_fire;
    assign buf_wdata = wr_beat.data;

    always_comb begin
        rd_beat.valid = rd_valid;
        rd_beat.data  = buf_rdata;
    end

    assign wr_ready = busy && !dir;
    assign idle     = !busy;

endmodule

// ==== rtl/ckpt_buffer.sv ====
`timescale 1ns/1ps
`include "ckpt_settings.svh"

module ckpt_buffer (
    input  logic                    host_clk,
    input  logic                    dma_we,
    input  logic [`CKPT_BUF_AW-1:0] dma_addr,
    input  ckpt_pkg::scan_word_t    dma_wdata,
    output ckpt_pkg::scan_word_t    dma_rdata,
    input  ckpt_pkg::buf_host_t     host,
    output ckpt_pkg::scan_word_t    host_rdata
);

    ckpt_pkg::scan_word_t mem [`CKPT_BUF_DEPTH];

    // Host writes only occur while the DMA is idle, so the two ports never collide
    always_ff @(posedge host_clk) begin
        if (dma_we) begin
            mem[dma_addr] <= dma_wdata;
        end
        if (host.we) begin
            mem[host.addr] <= host.wdata;
        end
    end

    always_ff @(posedge host_clk) begin
        dma_rdata <= mem[dma_addr];
    end

    // The register window needs the word in the same cycle as the read
    assign host_rdata = mem[host.addr];

endmodule

// ==== rtl/ckpt_pkg.sv ====
`include "ckpt_settings.svh"

package ckpt_pkg;

    typedef logic [`CKPT_WORD_W-1:0] scan_word_t;

    // One host register write
    typedef struct packed {
        logic                     en;
        logic [`CKPT_CTRL_AW-1:0] addr;
        logic [31:0]              data;
    } ctrl_wr_t;

    // Host side of the checkpoint buffer, the address also selects the read word
    typedef struct packed {
        logic                    we;
        logic [`CKPT_BUF_AW-1:0] addr;
        scan_word_t              wdata;
    } buf_host_t;

    typedef struct packed {
        logic       valid;
        scan_word_t data;
    } scan_beat_t;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_ADDR,
        ST_COUNT,
        ST_FF_RESET,
        ST_FF_SCAN,
        ST_RAM_RESET,
        ST_RAM_PREP1,
        ST_RAM_PREP2,
        ST_RAM_SCAN
    } scan_state_e;

endpackage

// ==== rtl/ckpt_settings.svh ====
`ifndef CKPT_SETTINGS_SVH
`define CKPT_SETTINGS_SVH

// Scan target geometry, in 64-bit words
`define CKPT_FF_COUNT       4
`define CKPT_MEM_COUNT      8
`define CKPT_WORD_W         64

// Buffer must hold FF_COUNT plus MEM_COUNT words
`define CKPT_BUF_DEPTH      16
`define CKPT_BUF_AW         ($clog2(`CKPT_BUF_DEPTH))

`define CKPT_CTRL_AW        6
`define CKPT_REG_DMA_CTRL   6'd0
`define CKPT_REG_BUF_ADDR   6'd1
`define CKPT_REG_BUF_LO     6'd2
`define CKPT_REG_BUF_HI     6'd3

`endif
